// File: src/sys1_rom_pkg.sv
// ####################
// Shared widths, bases and payload types of the ROM store
// Bases are byte addresses of the download stream, regions must not overlap
// ####################

package sys1_rom_pkg;

	// ####################
	// Payload and address types
	// ####################

	// Main program ROM word
	typedef logic [15:0] rom_word_t;
	// Sound ROM, PROM and download byte
	typedef logic [7:0]  rom_byte_t;
	// Download byte address
	typedef logic [24:0] load_addr_t;
	// Slapstic chip type
	typedef logic [7:0]  slap_type_t;

	// Bank counts of the two selected read paths
	localparam int MAIN_BANKS  = 5;
	localparam int SOUND_BANKS = 3;

	// ####################
	// Region address widths
	// ####################

	// Word address of ROM1 and ROM2
	localparam int MAIN_WIDE_AW   = 15;
	// Word address of ROM0, ROM3 and SLAP
	localparam int MAIN_NARROW_AW = 14;
	localparam int SOUND_AW       = 14;
	localparam int VPROM_AW       = 13;
	localparam int CPROM_AW       = 9;

	// Byte-address span of the word regions, one bit above the word address
	localparam int MAIN_WIDE_BW   = MAIN_WIDE_AW + 1;
	localparam int MAIN_NARROW_BW = MAIN_NARROW_AW + 1;

	// ####################
	// Region bases
	// ####################

	// 64 KB main banks
	localparam load_addr_t ROM1_BASE    = 25'h0080000;
	localparam load_addr_t ROM2_BASE    = 25'h0090000;
	// 32 KB main banks, SLAP is the slapstic bank
	localparam load_addr_t ROM3_BASE    = 25'h00A0000;
	localparam load_addr_t SLAP_BASE    = 25'h00A8000;
	localparam load_addr_t ROM0_BASE    = 25'h00B0000;
	// 16 KB sound banks
	localparam load_addr_t SND0_BASE    = 25'h00B8000;
	localparam load_addr_t SND1_BASE    = 25'h00BC000;
	localparam load_addr_t SND2_BASE    = 25'h00C0000;
	// 8 KB video PROM and two 512 byte colour PROMs
	localparam load_addr_t VPROM_BASE   = 25'h00C4000;
	localparam load_addr_t CPROM_A_BASE = 25'h00C6000;
	localparam load_addr_t CPROM_B_BASE = 25'h00C6200;

	// Download record indices
	localparam rom_byte_t LOAD_INDEX_ROM  = 8'd0;
	localparam rom_byte_t LOAD_INDEX_SLAP = 8'd1;

	// Slapstic type out of reset
	localparam slap_type_t SLAP_TYPE_DEFAULT = 8'd105;

endpackage

// File: src/rom_bank.sv
// ####################
// Dual-port ROM region, loader writes and board reads on clk_sys
// Read data lags the address by one clock, contents survive reset
// ####################
`timescale 1ns/1ps

module rom_bank import sys1_rom_pkg::*; #(
	parameter type payload_t = rom_byte_t,
	parameter int  AW        = 9
) (
	input  logic          clk_sys,
	// Loader side
	input  logic          wr_en,
	input  logic [AW-1:0] wr_addr,
	input  payload_t      wr_data,
	// Board side
	input  logic [AW-1:0] rd_addr,
	output payload_t      rd_data
);

	// Storage, maps onto block RAM
	payload_t mem [2**AW];

	// Write port
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Registered read port
	// Same-address write in the same cycle returns the old word
	always_ff @(posedge clk_sys) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// File: src/rom_load_decoder.sv
// ####################
// Download decoder, one region enable per accepted byte
// Main words need the even byte directly before its odd partner
// ####################
`timescale 1ns/1ps

module rom_load_decoder import sys1_rom_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	// Download stream
	input  logic       load_wr,
	input  logic       load_active,
	input  rom_byte_t  load_index,
	input  load_addr_t load_addr,
	input  rom_byte_t  load_data,
	// Region write enables, main order is ROM0, ROM1, ROM2, ROM3, SLAP
	output logic [MAIN_BANKS-1:0]  main_wr,
	output logic [SOUND_BANKS-1:0] snd_wr,
	output logic                   vprom_wr,
	output logic [1:0]             cprom_wr,
	// Assembled main word
	output rom_word_t  load_word,
	output slap_type_t slap_type
);

	// Qualified byte strobes
	logic rom_byte;
	logic slap_byte;
	// Odd byte closes a main word
	logic word_byte;
	// Last accepted ROM byte
	rom_byte_t acc_byte;

	// Address lies inside the region of 2**bw bytes at base
	function automatic logic in_region(
		input load_addr_t  addr,
		input load_addr_t  base,
		input int unsigned bw
	);
		in_region = ((addr ^ base) >> bw) == '0;
	endfunction

	// ####################
	// Byte qualification
	// ####################

	// ROM data only while the download level is up
	assign rom_byte  = load_wr && load_active && (load_index == LOAD_INDEX_ROM);
	// Slapstic record is taken regardless of the level
	assign slap_byte = load_wr && (load_index == LOAD_INDEX_SLAP);
	assign word_byte = rom_byte && load_addr[0];

	// ####################
	// Region decode
	// ####################

	// Main banks, written once per byte pair
	assign main_wr[0] = word_byte && in_region(load_addr, ROM0_BASE, MAIN_NARROW_BW);
	assign main_wr[1] = word_byte && in_region(load_addr, ROM1_BASE, MAIN_WIDE_BW);
	assign main_wr[2] = word_byte && in_region(load_addr, ROM2_BASE, MAIN_WIDE_BW);
	assign main_wr[3] = word_byte && in_region(load_addr, ROM3_BASE, MAIN_NARROW_BW);
	assign main_wr[4] = word_byte && in_region(load_addr, SLAP_BASE, MAIN_NARROW_BW);

	// Sound banks, every byte
	assign snd_wr[0] = rom_byte && in_region(load_addr, SND0_BASE, SOUND_AW);
	assign snd_wr[1] = rom_byte && in_region(load_addr, SND1_BASE, SOUND_AW);
	assign snd_wr[2] = rom_byte && in_region(load_addr, SND2_BASE, SOUND_AW);

	// PROMs
	assign vprom_wr    = rom_byte && in_region(load_addr, VPROM_BASE, VPROM_AW);
	assign cprom_wr[0] = rom_byte && in_region(load_addr, CPROM_A_BASE, CPROM_AW);
	assign cprom_wr[1] = rom_byte && in_region(load_addr, CPROM_B_BASE, CPROM_AW);

	// Even byte is the high half
	assign load_word = {acc_byte, load_data};

	// ####################
	// Byte history and slapstic type
	// ####################

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			acc_byte  <= '0;
			slap_type <= SLAP_TYPE_DEFAULT;
		end else begin
			if (rom_byte) begin
				acc_byte <= load_data;
			end
			if (slap_byte) begin
				slap_type <= load_data;
			end
		end
	end

	// Regions are disjoint, so no byte lands in two banks
	a_one_region : assert property (@(posedge clk_sys) disable iff (!rst_n)
		$onehot0({main_wr, snd_wr, vprom_wr, cprom_wr}))
		else $error("download byte hit more than one ROM region");

endmodule

// File: src/main_rom_select.sv
// ####################
// Five main program banks behind the board's ROM selects
// Selects are active low and ROM0 wins over ROM1..ROM3 with SLAP last
// ####################
`timescale 1ns/1ps

module main_rom_select import sys1_rom_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	// Loader side
	input  logic [MAIN_BANKS-1:0]   main_wr,
	input  load_addr_t              load_addr,
	input  rom_word_t               load_word,
	// Board side
	input  logic [MAIN_WIDE_AW-1:0] main_addr,
	input  logic [3:0]              rom_n,
	input  logic                    slap_n,
	output rom_word_t               main_data
);

	// Bank read data in main_wr index order
	rom_word_t bank_q [MAIN_BANKS];
	// Selects delayed to line up with the bank read
	logic [MAIN_BANKS-1:0] sel_n_q;

	// ####################
	// Banks
	// ####################

	for (genvar gi = 0; gi < MAIN_BANKS; gi++) begin : g_bank
		// ROM1 and ROM2 are the 64 KB banks
		localparam int BANK_AW = (gi == 1 || gi == 2) ? MAIN_WIDE_AW : MAIN_NARROW_AW;

		// Word address is the byte address without bit 0
		rom_bank #(
			.payload_t (rom_word_t),
			.AW        (BANK_AW)
		) u_bank (
			.clk_sys (clk_sys),
			.wr_en   (main_wr[gi]),
			.wr_addr (load_addr[BANK_AW:1]),
			.wr_data (load_word),
			.rd_addr (main_addr[BANK_AW-1:0]),
			.rd_data (bank_q[gi])
		);
	end

	// ####################
	// Select pipeline and mux
	// ####################

	// Out of reset nothing is selected, so main_data reads zero
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			sel_n_q <= '1;
		end else begin
			sel_n_q <= {slap_n, rom_n};
		end
	end

	// Lowest select index has priority
	always_comb begin
		main_data = '0;
		for (int i = MAIN_BANKS - 1; i >= 0; i--) begin
			if (!sel_n_q[i]) begin
				main_data = bank_q[i];
			end
		end
	end

endmodule

// File: src/sound_rom_select.sv
// ####################
// Three sound program banks behind active-low selects
// The sound CPU drives at most one select at a time
// ####################
`timescale 1ns/1ps

module sound_rom_select import sys1_rom_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	// Loader side
	input  logic [SOUND_BANKS-1:0] snd_wr,
	input  load_addr_t             load_addr,
	input  rom_byte_t              load_data,
	// Board side
	input  logic [SOUND_AW-1:0]    snd_addr,
	input  logic [SOUND_BANKS-1:0] srom_n,
	output rom_byte_t              snd_data
);

	rom_byte_t bank_q [SOUND_BANKS];
	logic [SOUND_BANKS-1:0] sel_n_q;

	// One 16 KB bank per select
	for (genvar gi = 0; gi < SOUND_BANKS; gi++) begin : g_bank
		rom_bank #(
			.payload_t (rom_byte_t),
			.AW        (SOUND_AW)
		) u_bank (
			.clk_sys (clk_sys),
			.wr_en   (snd_wr[gi]),
			.wr_addr (load_addr[SOUND_AW-1:0]),
			.wr_data (load_data),
			.rd_addr (snd_addr),
			.rd_data (bank_q[gi])
		);
	end

	// Selects follow the address through the read register
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			sel_n_q <= '1;
		end else begin
			sel_n_q <= srom_n;
		end
	end

	// srom_n[0] first
	always_comb begin
		snd_data = '0;
		for (int i = SOUND_BANKS - 1; i >= 0; i--) begin
			if (!sel_n_q[i]) begin
				snd_data = bank_q[i];
			end
		end
	end

	a_one_select : assert property (@(posedge clk_sys) disable iff (!rst_n)
		$onehot0(~srom_n))
		else $error("more than one sound ROM select low");

endmodule

// File: src/prom_store.sv
// ####################
// Video PROM and both colour PROMs, read in parallel
// Colour PROMs share one address, one clock of read latency
// ####################
`timescale 1ns/1ps

module prom_store import sys1_rom_pkg::*; (
	input  logic                clk_sys,
	// Loader side
	input  logic                vprom_wr,
	input  logic [1:0]          cprom_wr,
	input  load_addr_t          load_addr,
	input  rom_byte_t           load_data,
	// Board side
	input  logic [VPROM_AW-1:0] vprom_addr,
	input  logic [CPROM_AW-1:0] cprom_addr,
	output rom_byte_t           vprom_data,
	output rom_byte_t           cprom_a_data,
	output rom_byte_t           cprom_b_data
);

	// Video PROM, 8 KB
	rom_bank #(
		.payload_t (rom_byte_t),
		.AW        (VPROM_AW)
	) u_vprom (
		.clk_sys (clk_sys),
		.wr_en   (vprom_wr),
		.wr_addr (load_addr[VPROM_AW-1:0]),
		.wr_data (load_data),
		.rd_addr (vprom_addr),
		.rd_data (vprom_data)
	);

	// Colour PROM A
	rom_bank #(
		.payload_t (rom_byte_t),
		.AW        (CPROM_AW)
	) u_cprom_a (
		.clk_sys (clk_sys),
		.wr_en   (cprom_wr[0]),
		.wr_addr (load_addr[CPROM_AW-1:0]),
		.wr_data (load_data),
		.rd_addr (cprom_addr),
		.rd_data (cprom_a_data)
	);

	// Colour PROM B, same read address as A
	rom_bank #(
		.payload_t (rom_byte_t),
		.AW        (CPROM_AW)
	) u_cprom_b (
		.clk_sys (clk_sys),
		.wr_en   (cprom_wr[1]),
		.wr_addr (load_addr[CPROM_AW-1:0]),
		.wr_data (load_data),
		.rd_addr (cprom_addr),
		.rd_data (cprom_b_data)
	);

endmodule

// File: src/sys1_rom_store.sv
// ####################
// ROM store top, download stream in, three board read paths out
// No back-pressure, every download byte is taken on its strobe
// ####################
`timescale 1ns/1ps

module sys1_rom_store import sys1_rom_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	// Download stream
	input  logic                    load_wr,
	input  logic                    load_active,
	input  rom_byte_t               load_index,
	input  load_addr_t              load_addr,
	input  rom_byte_t               load_data,
	// Main program read
	input  logic [MAIN_WIDE_AW-1:0] main_addr,
	input  logic [3:0]              rom_n,
	input  logic                    slap_n,
	// Sound program read
	input  logic [SOUND_AW-1:0]     snd_addr,
	input  logic [SOUND_BANKS-1:0]  srom_n,
	// PROM read
	input  logic [VPROM_AW-1:0]     vprom_addr,
	input  logic [CPROM_AW-1:0]     cprom_addr,
	// Read data, one clock after the address
	output rom_word_t               main_data,
	output rom_byte_t               snd_data,
	output rom_byte_t               vprom_data,
	output rom_byte_t               cprom_a_data,
	output rom_byte_t               cprom_b_data,
	output slap_type_t              slap_type
);

	// Loader to region wires
	logic [MAIN_BANKS-1:0]  main_wr;
	logic [SOUND_BANKS-1:0] snd_wr;
	logic                   vprom_wr;
	logic [1:0]             cprom_wr;
	rom_word_t              load_word;

	// Download decode
	rom_load_decoder u_decoder (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.load_wr     (load_wr),
		.load_active (load_active),
		.load_index  (load_index),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.main_wr     (main_wr),
		.snd_wr      (snd_wr),
		.vprom_wr    (vprom_wr),
		.cprom_wr    (cprom_wr),
		.load_word   (load_word),
		.slap_type   (slap_type)
	);

	// Main CPU program
	main_rom_select u_main (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.main_wr   (main_wr),
		.load_addr (load_addr),
		.load_word (load_word),
		.main_addr (main_addr),
		.rom_n     (rom_n),
		.slap_n    (slap_n),
		.main_data (main_data)
	);

	// Sound CPU program
	sound_rom_select u_sound (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.snd_wr    (snd_wr),
		.load_addr (load_addr),
		.load_data (load_data),
		.snd_addr  (snd_addr),
		.srom_n    (srom_n),
		.snd_data  (snd_data)
	);

	// Video and colour PROMs
	prom_store u_prom (
		.clk_sys      (clk_sys),
		.vprom_wr     (vprom_wr),
		.cprom_wr     (cprom_wr),
		.load_addr    (load_addr),
		.load_data    (load_data),
		.vprom_addr   (vprom_addr),
		.cprom_addr   (cprom_addr),
		.vprom_data   (vprom_data),
		.cprom_a_data (cprom_a_data),
		.cprom_b_data (cprom_b_data)
	);

endmodule

// File: verif/tb_sys1_rom_store.sv
// ####################
// Testbench of the ROM store that applies one record of verif/sys1_rom_testdata.txt per clock
// Reads are checked one clock after their address and the first mismatch ends the run
// ####################
`timescale 1ns/1ps

module tb_sys1_rom_store import sys1_rom_pkg::*; ();

	// 8 ns clock
	localparam int CLK_HALF_NS   = 4;
	localparam int RESET_CYCLES  = 10;
	localparam int MARGIN_CYCLES = 50;
	localparam int MAX_RECORDS   = 256;

	// Record kind sits in the top hex digit
	localparam logic [3:0] KIND_LOAD      = 4'h1;
	localparam logic [3:0] KIND_LOAD_IDLE = 4'h2;
	localparam logic [3:0] KIND_MAIN      = 4'h3;
	localparam logic [3:0] KIND_SOUND     = 4'h4;
	localparam logic [3:0] KIND_PROM      = 4'h5;
	localparam logic [3:0] KIND_SLAP      = 4'h6;
	localparam logic [3:0] KIND_END       = 4'hF;

	logic                    clk_sys;
	logic                    rst_n;
	logic                    load_wr;
	logic                    load_active;
	rom_byte_t               load_index;
	load_addr_t              load_addr;
	rom_byte_t               load_data;
	logic [MAIN_WIDE_AW-1:0] main_addr;
	logic [3:0]              rom_n;
	logic                    slap_n;
	logic [SOUND_AW-1:0]     snd_addr;
	logic [SOUND_BANKS-1:0]  srom_n;
	logic [VPROM_AW-1:0]     vprom_addr;
	logic [CPROM_AW-1:0]     cprom_addr;
	rom_word_t               main_data;
	rom_byte_t               snd_data;
	rom_byte_t               vprom_data;
	rom_byte_t               cprom_a_data;
	rom_byte_t               cprom_b_data;
	slap_type_t              slap_type;

	// Record fields are kind, select or index, address and data
	logic [63:0] records [MAX_RECORDS];
	int          n_records;
	int          checks_expected;
	int          checks_done;
	logic        counted;

	sys1_rom_store dut0 (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.load_wr      (load_wr),
		.load_active  (load_active),
		.load_index   (load_index),
		.load_addr    (load_addr),
		.load_data    (load_data),
		.main_addr    (main_addr),
		.rom_n        (rom_n),
		.slap_n       (slap_n),
		.snd_addr     (snd_addr),
		.srom_n       (srom_n),
		.vprom_addr   (vprom_addr),
		.cprom_addr   (cprom_addr),
		.main_data    (main_data),
		.snd_data     (snd_data),
		.vprom_data   (vprom_data),
		.cprom_a_data (cprom_a_data),
		.cprom_b_data (cprom_b_data),
		.slap_type    (slap_type)
	);

	initial clk_sys = 1'b0;
	always #(CLK_HALF_NS) clk_sys = ~clk_sys;

	// ####################
	// Result checks
	// ####################

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input rom_word_t got, input rom_word_t exp, input string what);
		if (got !== exp) begin
			$display("** Error at %0t: %s returned %h, expected %h", $time, what, got, exp);
			abort_run();
		end else begin
			checks_done++;
		end
	endtask

	task automatic compare_byte(input rom_byte_t got, input rom_byte_t exp, input string what);
		if (got !== exp) begin
			$display("** Error at %0t: %s returned %h, expected %h", $time, what, got, exp);
			abort_run();
		end else begin
			checks_done++;
		end
	endtask

	task automatic expect_slap_type(input slap_type_t got, input slap_type_t exp, input int idx);
		if (got !== exp) begin
			$display("** Error at %0t: slapstic type %0d at record %0d, expected %0d",
				$time, got, idx, exp);
			abort_run();
		end else begin
			checks_done++;
		end
	endtask

	// ####################
	// Record handling
	// ####################

	// Scan up to the end marker to size the watchdog and the check count
	task automatic count_records();
		logic [3:0] kind;
		logic       found_end;
		found_end       = 1'b0;
		n_records       = 0;
		checks_expected = 0;
		for (int i = 0; i < MAX_RECORDS && !found_end; i++) begin
			kind = records[i][63:60];
			case (kind)
				KIND_END: begin
					found_end = 1'b1;
					n_records = i;
				end
				KIND_LOAD, KIND_LOAD_IDLE: ;
				KIND_MAIN, KIND_SOUND, KIND_SLAP: checks_expected += 1;
				// Three PROM bytes per read
				KIND_PROM: checks_expected += 3;
				default: begin
					$display("Record %0d of the test data is missing or of unknown kind", i);
					abort_run();
				end
			endcase
		end
		if (!found_end) begin
			$display("The test data has no end marker within %0d records", MAX_RECORDS);
			abort_run();
		end
	endtask

	// Drive one record with all selects idle unless the record reads
	task automatic apply_record(input logic [63:0] rec);
		logic [3:0] kind;
		kind = rec[63:60];
		load_wr <= 1'b0;
		rom_n   <= '1;
		slap_n  <= 1'b1;
		srom_n  <= '1;
		case (kind)
			KIND_LOAD, KIND_LOAD_IDLE: begin
				// One strobe per byte
				load_wr     <= 1'b1;
				load_active <= (kind == KIND_LOAD);
				load_index  <= rec[59:52];
				load_addr   <= rec[48:24];
				load_data   <= rec[7:0];
			end
			KIND_MAIN: begin
				{slap_n, rom_n} <= rec[56:52];
				main_addr       <= rec[24+MAIN_WIDE_AW-1:24];
			end
			KIND_SOUND: begin
				srom_n   <= rec[54:52];
				snd_addr <= rec[24+SOUND_AW-1:24];
			end
			KIND_PROM: begin
				// Video address in the upper four digits
				vprom_addr <= rec[36+VPROM_AW-1:36];
				cprom_addr <= rec[24+CPROM_AW-1:24];
			end
			default: ;
		endcase
	endtask

	// Compare what the record driven one clock earlier returned
	task automatic verify_record(input logic [63:0] rec, input int idx);
		case (rec[63:60])
			KIND_MAIN:  check_word(main_data, rec[15:0],
				$sformatf("main read %0d at %h", idx, rec[24+MAIN_WIDE_AW-1:24]));
			KIND_SOUND: compare_byte(snd_data, rec[7:0],
				$sformatf("sound read %0d at %h", idx, rec[24+SOUND_AW-1:24]));
			KIND_PROM: begin
				compare_byte(vprom_data, rec[23:16], $sformatf("video PROM read %0d", idx));
				compare_byte(cprom_a_data, rec[15:8], $sformatf("colour PROM A read %0d", idx));
				compare_byte(cprom_b_data, rec[7:0], $sformatf("colour PROM B read %0d", idx));
			end
			KIND_SLAP:  expect_slap_type(slap_type, rec[7:0], idx);
			default: ;
		endcase
	endtask

	// ####################
	// Stimulus
	// ####################

	initial begin
		logic [63:0] pending;
		logic        pending_valid;
		counted       = 1'b0;
		checks_done   = 0;
		pending       = '0;
		pending_valid = 1'b0;
		rst_n       <= 1'b0;
		load_wr     <= 1'b0;
		load_active <= 1'b0;
		load_index  <= '0;
		load_addr   <= '0;
		load_data   <= '0;
		main_addr   <= '0;
		rom_n       <= '1;
		slap_n      <= 1'b1;
		snd_addr    <= '0;
		srom_n      <= '1;
		vprom_addr  <= '0;
		cprom_addr  <= '0;
		$readmemh("verif/sys1_rom_testdata.txt", records);
		count_records();
		counted = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		rst_n <= 1'b1;
		// One extra pass flushes the last read
		for (int i = 0; i <= n_records; i++) begin
			@(posedge clk_sys);
			if (i < n_records) begin
				apply_record(records[i]);
			end else begin
				apply_record('0);
			end
			// Outputs of the previous record settled at this edge
			@(negedge clk_sys);
			if (pending_valid) begin
				verify_record(pending, i - 1);
			end
			pending       = records[i];
			pending_valid = 1'b1;
		end
		if (checks_done == checks_expected) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			$display("Only %0d of %0d expected checks ran", checks_done, checks_expected);
			abort_run();
		end
	end

	// Four clocks per record is far above the one clock each needs
	initial begin
		wait (counted === 1'b1);
		repeat (n_records * 4 + RESET_CYCLES + MARGIN_CYCLES) @(posedge clk_sys);
		$display("The run timed out, the watchdog expired before all records were done");
		abort_run();
	end

endmodule

// File: verif/sys1_rom_testdata.txt
// Columns: kind _ select or index _ address _ data, 1 load, 2 load with level low, 3 main,
// 4 sound, 5 PROM (video and colour address, three bytes), 6 slapstic type, F end
6_00_0000000_000069
3_1F_0000000_000000
1_00_00B8010_00005A
1_01_00B8010_000074
6_00_0000000_000074
4_06_0000010_00005A
1_00_00B0246_000012
1_00_00B0247_000034
1_00_0080246_0000AB
1_00_0080247_0000CD
1_00_0090246_00005E
1_00_0090247_0000A1
1_00_00A0246_0000C3
1_00_00A0247_00003C
1_00_00A8246_000096
1_00_00A8247_000069
1_00_0088ACE_00000F
1_00_0088ACF_0000F0
1_00_009FFFE_00007E
1_00_009FFFF_0000E7
3_1E_0000123_001234
3_1D_0000123_00ABCD
3_1B_0000123_005EA1
3_17_0000123_00C33C
3_0F_0000123_009669
3_00_0000123_001234
3_01_0000123_00ABCD
3_03_0000123_005EA1
3_07_0000123_00C33C
3_15_0000123_00ABCD
3_1F_0000123_000000
3_1D_0004567_000FF0
3_0F_0000123_009669
3_1B_0007FFF_007EE7
3_1E_0000123_001234
1_00_00B9234_000081
1_00_00BD234_000082
1_00_00C1234_000083
4_06_0001234_000081
4_05_0001234_000082
4_03_0001234_000083
4_07_0001234_000000
1_00_00C5ABC_00003D
1_00_00C61F5_0000A5
1_00_00C63F5_0000C7
5_00_1ABC1F5_3DA5C7
2_00_00B9234_0000FF
4_06_0001234_000081
2_00_00B0246_0000EE
2_00_00B0247_0000EE
3_1E_0000123_001234
1_00_00A0246_000077
3_17_0000123_00C33C
1_00_00A0247_000088
3_17_0000123_007788
F_00_0000000_000000

// File: all.f
src/sys1_rom_pkg.sv
src/rom_bank.sv
src/rom_load_decoder.sv
src/main_rom_select.sv
src/sound_rom_select.sv
src/prom_store.sv
src/sys1_rom_store.sv
verif/tb_sys1_rom_store.sv
